// ==== src.f ====
+incdir+tests
design/yuv_pkg.sv
design/skid_buffer.sv
design/chroma_window.sv
design/chroma_interp.sv
design/colour_convert.sv
design/yuv_to_rgb_top.sv
tests/tb_yuv_to_rgb.sv

// ==== Makefile ====
# Verilator build and run for the YUV to RGB pipeline

VERILATOR ?= verilator
TOP       ?= tb_yuv_to_rgb
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SIM_BIN := $(OBJ_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST))
HEADERS := $(wildcard tests/*.svh)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES) $(HEADERS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# Fails unless the pass line shows up in the output
run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '*** TEST PASSED ***'

clean:
	rm -rf $(OBJ_DIR)

// ==== tests/tb_ref_model.svh ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Reference model for YUV to RGB
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

// Needs ROW_PAIRS from the including module
typedef yuv_pkg::yuv_pair_t [ROW_PAIRS-1:0] row_t;

function automatic int clip_sample(input int val);
	if (val < 0) begin
		return 0;
	end
	if (val > 255) begin
		return 255;
	end
	return val;
endfunction

// Chroma of pair k, row ends replicated
function automatic int chroma_at(input row_t row, input int ch, input int k);
	int idx;
	idx = (k < 0) ? 0 : ((k > ROW_PAIRS - 1) ? ROW_PAIRS - 1 : k);
	return (ch == 0) ? int'(row[idx].u) : int'(row[idx].v);
endfunction

// Sample halfway between pair k and pair k+1
function automatic int half_sample(input row_t row, input int ch, input int k);
	int acc;
	acc = 21 * (chroma_at(row, ch, k - 2) + chroma_at(row, ch, k + 3))
		- 52 * (chroma_at(row, ch, k - 1) + chroma_at(row, ch, k + 2))
		+ 159 * (chroma_at(row, ch, k) + chroma_at(row, ch, k + 1))
		+ 128;
	return clip_sample(acc >>> 8);
endfunction

function automatic yuv_pkg::rgb_t pixel_rgb(input int y, input int u, input int v);
	yuv_pkg::rgb_t px;
	int            yt;
	yt   = 76284 * (y - 16);
	px.r = 8'(clip_sample((yt + 104595 * (v - 128)) >>> 16));
	px.g = 8'(clip_sample((yt - 25624 * (u - 128) - 53281 * (v - 128)) >>> 16));
	px.b = 8'(clip_sample((yt + 132251 * (u - 128)) >>> 16));
	return px;
endfunction

function automatic yuv_pkg::rgb_pair_t expected_pair(input row_t row, input int k);
	yuv_pkg::rgb_pair_t res;
	res.rgb_even = pixel_rgb(int'(row[k].y_even), chroma_at(row, 0, k), chroma_at(row, 1, k));
	res.rgb_odd  = pixel_rgb(int'(row[k].y_odd), half_sample(row, 0, k),
		half_sample(row, 1, k));
	return res;
endfunction

`endif

// ==== tests/tb_yuv_to_rgb.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// YUV to RGB pipeline testbench
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module tb_yuv_to_rgb;

	timeunit 1ns;
	timeprecision 100ps;

	import yuv_pkg::*;

	localparam int ROW_PAIRS   = 8;
	localparam int NUM_TESTS   = 8;
	localparam int TIMEOUT_CYC = NUM_TESTS * ROW_PAIRS * 4 + 200;

	`include "tb_ref_model.svh"

	// Ready mode 0 is always ready, 1 random, 2 mostly stalled
	string test_name [NUM_TESTS] = '{"flat_grey", "clip_high", "clip_low", "spike_ramp",
		"row_a_chroma", "row_b_chroma", "random_stall", "heavy_stall"};
	int    pattern [NUM_TESTS]    = '{0, 1, 2, 3, 4, 5, 6, 6};
	int    ready_mode [NUM_TESTS] = '{0, 0, 0, 0, 0, 0, 1, 2};

	logic      CLOCK_50_I = 1'b0;
	logic      resetn;
	yuv_pair_t in_data;
	logic      in_valid;
	logic      in_ready;
	rgb_pair_t out_data;
	logic      out_valid;
	logic      out_ready;

	int        seed        = 32'h0118_2f46;
	int        cur_mode    = 0;
	int        error_count = 0;
	int        check_count = 0;
	int        cycle_cnt;
	rgb_pair_t exp_q [$];
	int        tag_q [$];

	yuv_to_rgb_top #(.ROW_PAIRS(ROW_PAIRS)) yuv_to_rgb_top_i (
		.CLOCK_50_I(CLOCK_50_I),
		.resetn(resetn),
		.in_data(in_data),
		.in_valid(in_valid),
		.in_ready(in_ready),
		.out_data(out_data),
		.out_valid(out_valid),
		.out_ready(out_ready)
	);

	always #5 CLOCK_50_I = ~CLOCK_50_I;

	task automatic report_summary();
		$display("Summary: %0d output checks, %0d errors", check_count, error_count);
	endtask

	// One clock and then a fresh out_ready draw
	task automatic next_cycle();
		@(posedge CLOCK_50_I);
		#1;
		case (cur_mode)
			0: out_ready = 1'b1;
			1: out_ready = ($random(seed) & 1) != 0;
			default: out_ready = ($random(seed) & 3) == 0;
		endcase
	endtask

	function automatic row_t make_row(input int code);
		row_t row;
		for (int k = 0; k < ROW_PAIRS; k++) begin
			case (code)
				0: row[k] = '{y_even: 8'd120, y_odd: 8'd120, u: 8'd128, v: 8'd128};
				1: row[k] = '{y_even: 8'd255, y_odd: 8'd255, u: 8'd128, v: 8'd255};
				2: row[k] = '{y_even: 8'd0, y_odd: 8'd0, u: 8'd0, v: 8'd128};
				3: begin
					row[k].y_even = 8'(40 + 16 * k);
					row[k].y_odd  = 8'(48 + 16 * k);
					row[k].u      = (k == 3) ? 8'd255 : 8'd16;  // Lone spike
					row[k].v      = 8'(32 * k);
				end
				4: row[k] = '{y_even: 8'(60 + 20 * k), y_odd: 8'(70 + 20 * k), u: 8'd200, v: 8'd60};
				5: row[k] = '{y_even: 8'(200 - 15 * k), y_odd: 8'(190 - 15 * k), u: 8'd40,
					v: 8'd220};
				default: begin
					row[k].y_even = 8'($random(seed));
					row[k].y_odd  = 8'($random(seed));
					row[k].u      = 8'($random(seed));
					row[k].v      = 8'($random(seed));
				end
			endcase
		end
		return row;
	endfunction

	task automatic send_pair(input yuv_pair_t pair, input bit gaps);
		bit taken;
		if (gaps) begin
			while (($random(seed) & 3) == 0) begin
				in_valid = 1'b0;
				next_cycle();
			end
		end
		in_data  = pair;
		in_valid = 1'b1;
		do begin
			taken = in_ready;  // Registered so it holds until the edge
			next_cycle();
		end while (!taken);
		in_valid = 1'b0;
	endtask

	// Outputs are stable at the falling edge
	always @(negedge CLOCK_50_I) begin : monitor
		rgb_pair_t exp;
		int        tag;
		if (resetn && out_valid && out_ready) begin
			check_count++;
			assert (exp_q.size() > 0) else begin
				$display("Output beat arrived with no expected beat left");
				error_count++;
			end
			if (exp_q.size() > 0) begin
				exp = exp_q.pop_front();
				tag = tag_q.pop_front();
				assert (out_data == exp) else begin
					$display("FAILED %s expected %h actual %h", test_name[tag], exp, out_data);
					error_count++;
				end
				if (pattern[tag] == 0) begin
					assert (out_data.rgb_even == {3{out_data.rgb_even.r}} &&
						out_data.rgb_odd == {3{out_data.rgb_odd.r}}) else begin
						$display("FAILED %s expected grey pixels actual %h",
							test_name[tag], out_data);
						error_count++;
					end
				end
			end
		end
	end

	initial begin : stimulus
		row_t row;
		resetn    = 1'b0;
		in_valid  = 1'b0;
		in_data   = '0;
		out_ready = 1'b0;
		repeat (10) @(posedge CLOCK_50_I);
		#1;
		resetn = 1'b1;
		repeat (3) begin
			assert (!out_valid && in_ready) else begin
				$display("FAILED after_reset expected out_valid 0 in_ready 1 actual %b %b",
					out_valid, in_ready);
				error_count++;
			end
			next_cycle();
		end
		for (int t = 0; t < NUM_TESTS; t++) begin
			cur_mode = ready_mode[t];
			row      = make_row(pattern[t]);
			for (int k = 0; k < ROW_PAIRS; k++) begin
				exp_q.push_back(expected_pair(row, k));
				tag_q.push_back(t);
			end
			for (int k = 0; k < ROW_PAIRS; k++) begin
				send_pair(row[k], ready_mode[t] != 0);
			end
		end
		cur_mode = 0;
		while (exp_q.size() > 0) begin
			next_cycle();
		end
		repeat (20) begin
			next_cycle();  // Window for stray extra beats
		end
		assert (check_count == NUM_TESTS * ROW_PAIRS) else begin
			$display("Run produced %0d output beats instead of %0d",
				check_count, NUM_TESTS * ROW_PAIRS);
			error_count++;
		end
		report_summary();
		if (error_count == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

	initial begin : watchdog
		cycle_cnt = 0;
		while (cycle_cnt < TIMEOUT_CYC) begin
			@(posedge CLOCK_50_I);
			cycle_cnt++;
		end
		$display("Run did not finish within %0d cycles, the pipeline looks hung", TIMEOUT_CYC);
		error_count++;
		report_summary();
		$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

// ==== design/yuv_to_rgb_top.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// YUV 4:2:2 to RGB streaming top level
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module yuv_to_rgb_top #(
	parameter int ROW_PAIRS = 160
) (
	input  logic               CLOCK_50_I,
	input  logic               resetn,
	input  yuv_pkg::yuv_pair_t in_data,
	input  logic               in_valid,
	output logic               in_ready,
	output yuv_pkg::rgb_pair_t out_data,
	output logic               out_valid,
	input  logic               out_ready
);

	import yuv_pkg::*;

	yuv_pair_t                     buf_data;
	logic                          buf_valid;
	logic                          buf_ready;
	win_beat_t                     win_data;
	logic                          win_valid;
	chroma_pair_t [NUM_CHROMA-1:0] chroma;
	rgb_pair_t                     rgb_data;
	logic                          rgb_valid;
	logic                          rgb_ready;
	logic                          advance;

	skid_buffer #(.T(yuv_pair_t)) in_buf (
		.CLOCK_50_I(CLOCK_50_I),
		.resetn(resetn),
		.in_data(in_data),
		.in_valid(in_valid),
		.in_ready(in_ready),
		.out_data(buf_data),
		.out_valid(buf_valid),
		.out_ready(buf_ready)
	);

	chroma_window #(.ROW_PAIRS(ROW_PAIRS)) chroma_window_i (
		.CLOCK_50_I(CLOCK_50_I),
		.resetn(resetn),
		.in_data(buf_data),
		.in_valid(buf_valid),
		.in_ready(buf_ready),
		.advance(advance),
		.win_data(win_data),
		.win_valid(win_valid)
	);

	// One interpolator per chroma channel
	for (genvar i = 0; i < NUM_CHROMA; i++) begin : g_interp
		chroma_interp chroma_interp_i (
			.CLOCK_50_I(CLOCK_50_I),
			.resetn(resetn),
			.advance(advance),
			.win(win_data.win[i]),
			.chroma(chroma[i])
		);
	end

	colour_convert colour_convert_i (
		.CLOCK_50_I(CLOCK_50_I),
		.resetn(resetn),
		.win_data(win_data),
		.win_valid(win_valid),
		.chroma(chroma),
		.advance(advance),
		.rgb_data(rgb_data),
		.rgb_valid(rgb_valid),
		.rgb_ready(rgb_ready)
	);

	skid_buffer #(.T(rgb_pair_t)) out_buf (
		.CLOCK_50_I(CLOCK_50_I),
		.resetn(resetn),
		.in_data(rgb_data),
		.in_valid(rgb_valid),
		.in_ready(rgb_ready),
		.out_data(out_data),
		.out_valid(out_valid),
		.out_ready(out_ready)
	);

endmodule

// ==== design/colour_convert.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// YUV to RGB colour converter
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module colour_convert (
	input  logic                                          CLOCK_50_I,
	input  logic                                          resetn,
	input  yuv_pkg::win_beat_t                            win_data,
	input  logic                                          win_valid,
	input  yuv_pkg::chroma_pair_t [yuv_pkg::NUM_CHROMA-1:0] chroma,
	output logic                                          advance,
	output yuv_pkg::rgb_pair_t                            rgb_data,
	output logic                                          rgb_valid,
	input  logic                                          rgb_ready
);

	import yuv_pkg::*;

	typedef logic signed [31:0] acc_t;

	typedef struct packed {
		acc_t y;
		acc_t rv;
		acc_t gu;
		acc_t gv;
		acc_t bu;
	} csc_prod_t;

	logic                  v1;
	logic                  v2;
	logic                  v3;
	pix_t [1:0]            y1;   // Index 0 is the even pixel
	pix_t [1:0]            y2;
	pix_t [NUM_CHROMA-1:0] cen1; // Window centre taps, two stages like the interpolators
	pix_t [NUM_CHROMA-1:0] cen2;
	csc_prod_t [1:0]       prod;

	function automatic csc_prod_t csc_products(input pix_t y, input pix_t u, input pix_t v);
		csc_prod_t p;
		acc_t      yo;
		acc_t      uo;
		acc_t      vo;
		yo   = acc_t'(y) - Y_OFFSET;
		uo   = acc_t'(u) - C_OFFSET;
		vo   = acc_t'(v) - C_OFFSET;
		p.y  = yo * COEF_Y;
		p.rv = vo * COEF_RV;
		p.gu = uo * COEF_GU;
		p.gv = vo * COEF_GV;
		p.bu = uo * COEF_BU;
		return p;
	endfunction

	function automatic rgb_t csc_rgb(input csc_prod_t p);
		rgb_t c;
		c.r = clip_pix(int'((p.y + p.rv) >>> CSC_SHIFT));
		c.g = clip_pix(int'((p.y - p.gu - p.gv) >>> CSC_SHIFT));
		c.b = clip_pix(int'((p.y + p.bu) >>> CSC_SHIFT));
		return c;
	endfunction

	// Whole pipeline moves together and an empty last stage absorbs a bubble
	assign advance = rgb_ready | ~rgb_valid;

	always_ff @(posedge CLOCK_50_I or negedge resetn) begin
		if (!resetn) begin
			v1        <= 1'b0;
			v2        <= 1'b0;
			v3        <= 1'b0;
			rgb_valid <= 1'b0;
		end else if (advance) begin
			v1        <= win_valid;  // Matches interpolator latency
			v2        <= v1;
			v3        <= v2;
			rgb_valid <= v3;
		end
	end

	always_ff @(posedge CLOCK_50_I) begin
		if (advance) begin
			y1   <= {win_data.y_odd, win_data.y_even};
			y2   <= y1;
			cen1 <= {win_data.win[1][2], win_data.win[0][2]};
			cen2 <= cen1;
			// Stage 3
			prod[0] <= csc_products(y2[0], chroma[0].even, chroma[1].even);
			prod[1] <= csc_products(y2[1], chroma[0].odd, chroma[1].odd);
			// Stage 4
			rgb_data.rgb_even <= csc_rgb(prod[0]);
			rgb_data.rgb_odd  <= csc_rgb(prod[1]);
		end
	end

	// Chroma taken into stage 3 belongs to the window that carried the valid
	a_chroma_aligned: assert property (@(posedge CLOCK_50_I) disable iff (!resetn)
		v2 |-> chroma[0].even == cen2[0] && chroma[1].even == cen2[1]);

endmodule

// ==== design/chroma_interp.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Six-tap chroma interpolator
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module chroma_interp (
	input  logic                  CLOCK_50_I,
	input  logic                  resetn,
	input  logic                  advance,
	input  yuv_pkg::chroma_win_t  win,
	output yuv_pkg::chroma_pair_t chroma
);

	import yuv_pkg::*;

	logic [PIX_W:0] sum_outer;
	logic [PIX_W:0] sum_mid;
	logic [PIX_W:0] sum_inner;
	int             prod_outer;
	int             prod_mid;
	int             prod_inner;
	pix_t           centre_q;
	int             acc;

	// Filter is symmetric about the half-sample point
	assign sum_outer = {1'b0, win[0]} + {1'b0, win[5]};
	assign sum_mid   = {1'b0, win[1]} + {1'b0, win[4]};
	assign sum_inner = {1'b0, win[2]} + {1'b0, win[3]};

	assign acc = prod_inner - prod_mid + prod_outer + FIR_ROUND;

	always_ff @(posedge CLOCK_50_I or negedge resetn) begin
		if (!resetn) begin
			prod_outer <= 0;
			prod_mid   <= 0;
			prod_inner <= 0;
			centre_q   <= '0;
			chroma     <= '0;
		end else if (advance) begin
			// Stage 1
			prod_outer <= TAP_OUTER * int'(sum_outer);
			prod_mid   <= TAP_MID * int'(sum_mid);
			prod_inner <= TAP_INNER * int'(sum_inner);
			centre_q   <= win[2];
			// Stage 2
			chroma.even <= centre_q;            // Co-sited sample passes through
			chroma.odd  <= clip_pix(acc >>> FIR_SHIFT);  // Negative lobe clips to 0
		end
	end

endmodule

// ==== design/chroma_window.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Chroma tap window with row edge handling
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module chroma_window #(
	parameter int ROW_PAIRS = 160
) (
	input  logic               CLOCK_50_I,
	input  logic               resetn,
	input  yuv_pkg::yuv_pair_t in_data,
	input  logic               in_valid,
	output logic               in_ready,
	input  logic               advance,
	output yuv_pkg::win_beat_t win_data,
	output logic               win_valid
);

	import yuv_pkg::*;

	localparam int CNT_W = (ROW_PAIRS > 1) ? $clog2(ROW_PAIRS) : 1;
	localparam int LEAD  = 3;  // Look-ahead pairs, also flush length

	logic [CNT_W-1:0]             pair_cnt;
	logic                         flushing;
	logic [1:0]                   flush_cnt;
	logic                         last_q;
	logic                         accept;
	logic                         step;
	logic                         emit;
	logic                         row_end;
	logic                         flush_end;
	pix_t [NUM_CHROMA-1:0]        new_c;
	chroma_win_t [NUM_CHROMA-1:0] taps;
	pix_t [LEAD:0]                ye_dl;
	pix_t [LEAD:0]                yo_dl;

	assign new_c     = {in_data.v, in_data.u};
	assign in_ready  = advance & ~flushing;
	assign accept    = in_valid & in_ready;
	assign step      = accept | (flushing & advance);
	assign row_end   = (pair_cnt == CNT_W'(ROW_PAIRS - 1));
	assign flush_end = (flush_cnt == 2'(LEAD - 1));
	assign emit      = flushing | (pair_cnt >= CNT_W'(LEAD));  // First pairs only fill taps

	always_ff @(posedge CLOCK_50_I or negedge resetn) begin
		if (!resetn) begin
			pair_cnt  <= '0;
			flushing  <= 1'b0;
			flush_cnt <= '0;
			win_valid <= 1'b0;
			last_q    <= 1'b0;
		end else if (advance) begin
			win_valid <= step & emit;
			last_q    <= flushing & flush_end;
			if (accept) begin
				if (row_end) begin
					pair_cnt <= '0;
					flushing <= 1'b1;
				end else begin
					pair_cnt <= pair_cnt + 1'b1;
				end
			end
			if (flushing) begin
				if (flush_end) begin
					flushing  <= 1'b0;
					flush_cnt <= '0;
				end else begin
					flush_cnt <= flush_cnt + 2'd1;
				end
			end
		end
	end

	always_ff @(posedge CLOCK_50_I) begin
		if (step) begin
			for (int c = 0; c < NUM_CHROMA; c++) begin
				if (accept && pair_cnt == '0) begin
					taps[c] <= {WIN_TAPS{new_c[c]}};  // Replicate first sample
				end else if (accept) begin
					taps[c] <= {new_c[c], taps[c][WIN_TAPS-1:1]};
				end else begin
					taps[c] <= {taps[c][WIN_TAPS-1], taps[c][WIN_TAPS-1:1]};
				end
			end
			ye_dl <= {accept ? in_data.y_even : ye_dl[LEAD], ye_dl[LEAD:1]};
			yo_dl <= {accept ? in_data.y_odd : yo_dl[LEAD], yo_dl[LEAD:1]};
		end
	end

	always_comb begin
		win_data.y_even      = ye_dl[0];
		win_data.y_odd       = yo_dl[0];
		win_data.win         = taps;
		win_data.last_in_row = last_q;
	end

	// Next row may not start until the flush has pushed out three windows
	a_flush_blocks: assert property (@(posedge CLOCK_50_I) disable iff (!resetn)
		accept && row_end |=> !in_ready ##1 !in_ready ##1 !in_ready);

endmodule

// ==== design/skid_buffer.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Two-entry valid/ready skid buffer
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module skid_buffer #(
	parameter type T = yuv_pkg::pix_t
) (
	input  logic CLOCK_50_I,
	input  logic resetn,
	input  T     in_data,
	input  logic in_valid,
	output logic in_ready,
	output T     out_data,
	output logic out_valid,
	input  logic out_ready
);

	T           skid_data;
	logic       skid_valid;
	logic       in_fire;
	logic       load_main;
	logic [1:0] held;  // Beats taken in and not yet handed on

	assign in_ready  = ~skid_valid;          // Straight from a flop
	assign in_fire   = in_valid & in_ready;
	assign load_main = out_ready | ~out_valid;  // Main entry free or draining

	always_ff @(posedge CLOCK_50_I or negedge resetn) begin
		if (!resetn) begin
			out_valid  <= 1'b0;
			skid_valid <= 1'b0;
		end else if (load_main) begin
			out_valid  <= skid_valid | in_fire;
			skid_valid <= 1'b0;
		end else if (in_fire) begin
			skid_valid <= 1'b1;  // Main entry stalled so the beat parks here
		end
	end

	always_ff @(posedge CLOCK_50_I) begin
		if (load_main) begin
			out_data <= skid_valid ? skid_data : in_data;
		end
		if (in_fire && !load_main) begin
			skid_data <= in_data;
		end
	end

	always_ff @(posedge CLOCK_50_I or negedge resetn) begin
		if (!resetn) begin
			held <= '0;
		end else begin
			held <= held + 2'(in_fire) - 2'(out_valid & out_ready);
		end
	end

	// Every accepted beat sits in exactly one entry until it leaves
	a_no_loss: assert property (@(posedge CLOCK_50_I) disable iff (!resetn)
		held == 2'(out_valid) + 2'(skid_valid));

	// A refused beat waits upstream unchanged
	a_in_stable: assert property (@(posedge CLOCK_50_I) disable iff (!resetn)
		in_valid && !in_ready |=> in_valid && $stable(in_data));

endmodule

// ==== design/yuv_pkg.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// YUV 4:2:2 to RGB shared definitions
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package yuv_pkg;

	localparam int PIX_W      = 8;
	localparam int NUM_CHROMA = 2;  // 0 is U, 1 is V
	localparam int WIN_TAPS   = 6;

	typedef logic [PIX_W-1:0] pix_t;

	// One input beat, two pixels sharing one U and one V
	typedef struct packed {
		pix_t y_even;
		pix_t y_odd;
		pix_t u;
		pix_t v;
	} yuv_pair_t;

	// Tap 0 is pair k-2, tap 5 is pair k+3
	typedef pix_t [WIN_TAPS-1:0] chroma_win_t;

	typedef struct packed {
		pix_t                         y_even;
		pix_t                         y_odd;
		chroma_win_t [NUM_CHROMA-1:0] win;
		logic                         last_in_row;
	} win_beat_t;

	typedef struct packed {
		pix_t even;
		pix_t odd;
	} chroma_pair_t;

	typedef struct packed {
		pix_t r;
		pix_t g;
		pix_t b;
	} rgb_t;

	typedef struct packed {
		rgb_t rgb_even;
		rgb_t rgb_odd;
	} rgb_pair_t;

	// Six-tap half-sample filter
	localparam int TAP_OUTER = 21;
	localparam int TAP_MID   = 52;
	localparam int TAP_INNER = 159;
	localparam int FIR_ROUND = 128;
	localparam int FIR_SHIFT = 8;

	// Fixed-point colour matrix, 16 fractional bits
	localparam int COEF_Y    = 76284;
	localparam int COEF_RV   = 104595;
	localparam int COEF_GU   = 25624;
	localparam int COEF_GV   = 53281;
	localparam int COEF_BU   = 132251;
	localparam int Y_OFFSET  = 16;
	localparam int C_OFFSET  = 128;
	localparam int CSC_SHIFT = 16;

	// Saturate to one sample
	function automatic pix_t clip_pix(input int val);
		if (val < 0) begin
			return '0;
		end else if (val > 255) begin
			return pix_t'(255);
		end
		return pix_t'(val);
	endfunction

endpackage
